// ==== Makefile ====
# Verilator flow for the bus bridge slave testbench
VERILATOR  ?= verilator
TOP        := tb_bus_bridge_slave
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
verilog/bridge_pkg.sv
verilog/local_mem_if.sv
verilog/local_mem.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/bridge_ctrl.sv
verilog/bus_bridge_slave.sv
testbench/tb_remote_node.sv
testbench/tb_bus_bridge_slave.sv

// ==== testbench/tb_bus_bridge_slave.sv ====
// Testbench top with clock, reset, LFSR stimulus, reference model, compare tasks and watchdog
`timescale 1ns/1ps

module tb_bus_bridge_slave;

    localparam int clks_per_bit = 8;
    localparam int n_local      = 16;                 // Writes, then reads of the same addresses
    localparam int n_burst      = 16;                 // Back-to-back reads
    localparam int n_bridge     = 4;
    localparam int n_mixed      = 200;
    localparam int total_ops    = 2 * n_local + n_burst + 2 * n_bridge + n_mixed;
    localparam longint watchdog_ns = longint'(total_ops) * 60 * clks_per_bit * 40;

    logic               clk;
    logic               rstn;
    logic               req;
    bridge_pkg::op_e    req_op;
    bridge_pkg::addr_t  req_addr;
    bridge_pkg::data_t  req_wdata;
    logic               busy;
    logic               rsp_valid;
    bridge_pkg::data_t  rsp_rdata;
    logic               u_tx;
    logic               u_rx;
    bridge_pkg::frame_t node_frame;
    int                 node_count;

    // ----------------------------------------
    // Reference model and bookkeeping
    // ----------------------------------------
    bridge_pkg::data_t  local_model  [2048];
    bridge_pkg::data_t  remote_model [4096];
    logic               local_written [2048];     // Unwritten local bytes read as X
    bridge_pkg::addr_t  local_addrs  [n_local];
    bridge_pkg::addr_t  bridge_addrs [n_bridge];
    bridge_pkg::data_t  exp_data_q [$];           // Pending reads in issue order
    int                 exp_cycle_q [$];          // -1 for bridged reads
    logic [31:0]        lfsr_state = 32'hc8be_f9f3;
    int                 cycle_cnt;
    string              test_name;

    bus_bridge_slave #(.clks_per_bit(clks_per_bit), .local_depth(2048)) bus_bridge_slave_inst (
        .clk (clk), .rstn (rstn), .req (req), .req_op (req_op), .req_addr (req_addr),
        .req_wdata (req_wdata), .busy (busy), .rsp_valid (rsp_valid), .rsp_rdata (rsp_rdata),
        .u_tx (u_tx), .u_rx (u_rx)
    );

    tb_remote_node #(.clks_per_bit(clks_per_bit)) remote_node_inst (
        .clk (clk), .rstn (rstn), .u_tx (u_tx), .u_rx (u_rx),
        .last_frame (node_frame), .frame_count (node_count)
    );

    always #20 clk = ~clk;                        // 40 ns period
    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input bridge_pkg::data_t exp,
                              input bridge_pkg::data_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_frame(input string name, input bridge_pkg::frame_t exp,
                               input bridge_pkg::frame_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_cycle(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("CHECK FAILED %s latency expected cycle %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    // Response monitor, samples on the falling edge
    always @(negedge clk) begin
        if (rstn === 1'b1 && rsp_valid === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                $display("ERROR: rsp_valid at cycle %0d with no read pending", cycle_cnt);
                abort_run();
            end else begin
                if (exp_cycle_q[0] >= 0) check_cycle(test_name, exp_cycle_q[0], cycle_cnt);
                check_data(test_name, exp_data_q[0], rsp_rdata);
                void'(exp_data_q.pop_front());
                void'(exp_cycle_q.pop_front());
            end
        end
    end

    // ----------------------------------------
    // Requester tasks, entered 2 ns after an edge
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic require_idle();
        if (busy !== 1'b0) begin
            $display("ERROR: busy is high before a local request in %s", test_name);
            abort_run();
        end
    endtask

    task automatic local_write(input bridge_pkg::addr_t addr, input bridge_pkg::data_t data);
        require_idle();
        req       = 1'b1;
        req_op    = bridge_pkg::op_write;
        req_addr  = addr;
        req_wdata = data;
        local_model[addr[10:0]]   = data;
        local_written[addr[10:0]] = 1'b1;
        next_cycle();
        req = 1'b0;
    endtask

    task automatic local_read(input bridge_pkg::addr_t addr);
        require_idle();
        req       = 1'b1;
        req_op    = bridge_pkg::op_read;
        req_addr  = addr;
        req_wdata = '0;
        exp_data_q.push_back(local_model[addr[10:0]]);
        exp_cycle_q.push_back(cycle_cnt + 2);      // Registered read plus output register
        next_cycle();
        req = 1'b0;
    endtask

    task automatic bridge_op(input bridge_pkg::op_e op, input bridge_pkg::addr_t addr,
                             input bridge_pkg::data_t data);
        bridge_pkg::frame_t exp_frame;
        int                 count_before;
        exp_frame.mode = op;
        exp_frame.data = (op == bridge_pkg::op_write) ? data : '0;
        exp_frame.addr = addr;
        count_before   = node_count;
        req       = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = data;
        if (op == bridge_pkg::op_write) begin
            remote_model[addr] = data;
        end else begin
            exp_data_q.push_back(remote_model[addr]);
            exp_cycle_q.push_back(-1);                 // Latency set by the remote node
        end
        next_cycle();
        req = 1'b0;
        if (busy !== 1'b1) begin
            $display("ERROR: busy did not rise after a bridged request in %s", test_name);
            abort_run();
        end
        while (busy === 1'b1) next_cycle();
        @(negedge clk);
        #1;                                            // Monitor has taken the response
        if (node_count != count_before + 1) begin
            $display("ERROR: remote node decoded %0d frames instead of one",
                     node_count - count_before);
            abort_run();
        end
        check_frame(test_name, exp_frame, node_frame);
        if (exp_data_q.size() != 0) begin
            $display("ERROR: bridged operation ended with a read still unanswered");
            abort_run();
        end
        next_cycle();
    endtask

    // Watchdog sized from the operation count
    initial begin
        #(watchdog_ns * 1ns);
        $display("ERROR: run did not finish within %0d ns", watchdog_ns);
        abort_run();
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [31:0]       rnd;
        bridge_pkg::op_e   op;
        bridge_pkg::addr_t addr;
        bridge_pkg::data_t data;
        clk       = 1'b0;
        rstn      = 1'b0;
        req       = 1'b0;
        req_op    = bridge_pkg::op_read;
        req_addr  = '0;
        req_wdata = '0;
        cycle_cnt = 0;
        test_name = "reset";
        for (int a = 0; a < 2048; a++) local_written[a] = 1'b0;
        for (int a = 0; a < 4096; a++) remote_model[a] = bridge_pkg::data_t'(a) ^ 8'h5a;
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;
        next_cycle();

        test_name = "local write then read";
        for (int i = 0; i < n_local; i++) begin
            rnd            = rand_bits(11);
            local_addrs[i] = {1'b0, rnd[10:0]};
            rnd            = rand_bits(8);
            local_write(local_addrs[i], rnd[7:0]);
        end
        for (int i = 0; i < n_local; i++) begin
            local_read(local_addrs[i]);
            next_cycle();
            next_cycle();
        end

        test_name = "back-to-back local reads";
        for (int i = 0; i < n_burst; i++) begin
            rnd = rand_bits(4);
            local_read(local_addrs[rnd[3:0]]);
        end
        repeat (3) next_cycle();

        test_name = "bridged write";
        for (int i = 0; i < n_bridge; i++) begin
            rnd             = rand_bits(11);
            bridge_addrs[i] = {1'b1, rnd[10:0]};
            rnd             = rand_bits(8);
            bridge_op(bridge_pkg::op_write, bridge_addrs[i], rnd[7:0]);
        end

        test_name = "bridged read";
        for (int i = 0; i < n_bridge; i++) begin
            rnd  = rand_bits(11);
            addr = (i % 2 == 0) ? bridge_addrs[i] : {1'b1, rnd[10:0]};  // Written or initial
            bridge_op(bridge_pkg::op_read, addr, 8'h00);
        end

        test_name = "mixed random sequence";
        for (int i = 0; i < n_mixed; i++) begin
            rnd  = rand_bits(1);
            op   = rnd[0] ? bridge_pkg::op_write : bridge_pkg::op_read;
            rnd  = rand_bits(12);
            addr = rnd[11:0];
            rnd  = rand_bits(8);
            data = rnd[7:0];
            if (addr[11]) begin
                bridge_op(op, addr, data);
            end else if (op == bridge_pkg::op_write || !local_written[addr[10:0]]) begin
                local_write(addr, data);
            end else begin
                local_read(addr);
            end
        end
        repeat (3) next_cycle();

        if (exp_data_q.size() != 0) begin
            $display("ERROR: %0d reads were never answered", exp_data_q.size());
            abort_run();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== testbench/tb_remote_node.sv ====
// Remote UART node model with frame decoder, remote byte store and read responder
`timescale 1ns/1ps

module tb_remote_node #(
    parameter int clks_per_bit = 8
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               u_tx,                  // Frames from the bridge
    output logic               u_rx,                  // Response bytes to the bridge
    output bridge_pkg::frame_t last_frame,            // Last frame with a good stop bit
    output int                 frame_count
);

    localparam int gap_bits = 5;                      // Idle bits before a response

    bridge_pkg::data_t remote_mem [4096];

    // One bit on the line, changes 2 ns after a rising edge
    task automatic send_bit(input logic b);
        u_rx = b;
        repeat (clks_per_bit) @(posedge clk);
        #2;
    endtask

    task automatic send_byte(input bridge_pkg::data_t b);
        send_bit(1'b0);                               // Start
        for (int i = 0; i < 8; i++) begin
            send_bit(b[i]);                           // LSB first
        end
        send_bit(1'b1);                               // Stop
    endtask

    // Entered half a clock into the start bit, samples near mid-bit on falling edges
    task automatic receive_frame(output bridge_pkg::frame_t f, output logic stop_ok);
        logic [bridge_pkg::frame_width-1:0] bits;
        repeat (clks_per_bit / 2) @(negedge clk);
        for (int i = 0; i < bridge_pkg::frame_width; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            bits[i] = u_tx;
        end
        repeat (clks_per_bit) @(negedge clk);
        stop_ok = u_tx;
        f       = bridge_pkg::frame_t'(bits);
    endtask

    // ----------------------------------------
    // Decode loop
    // ----------------------------------------
    initial begin
        bridge_pkg::frame_t f;
        logic               stop_ok;
        u_rx        = 1'b1;                           // Line idles high
        frame_count = 0;
        last_frame  = '0;
        for (int a = 0; a < 4096; a++) begin
            remote_mem[a] = bridge_pkg::data_t'(a) ^ 8'h5a;   // Low address byte pattern
        end
        wait (rstn === 1'b1);
        forever begin
            @(negedge clk);
            if (u_tx === 1'b0) begin
                receive_frame(f, stop_ok);
                if (stop_ok) begin                    // Broken frames are not counted
                    last_frame  = f;
                    frame_count = frame_count + 1;
                    if (f.mode == bridge_pkg::op_write) begin
                        remote_mem[f.addr] = f.data;
                    end else begin
                        @(posedge clk);
                        #2;
                        repeat (gap_bits) send_bit(1'b1);
                        send_byte(remote_mem[f.addr]);
                    end
                end
            end
        end
    end

endmodule

// ==== verilog/bridge_ctrl.sv ====
// Bridge controller with address decode, bridge FSM, response mux and busy flag
`timescale 1ns/1ps

module bridge_ctrl (
    input  logic                clk,
    input  logic                rstn,
    input  logic                req,                  // One-cycle request strobe
    input  bridge_pkg::op_e     req_op,
    input  bridge_pkg::addr_t   req_addr,
    input  bridge_pkg::data_t   req_wdata,
    output logic                busy,
    output logic                rsp_valid,
    output bridge_pkg::data_t   rsp_rdata,
    local_mem_if.ctrl           mem,
    output logic                tx_start,
    output bridge_pkg::frame_t  tx_frame,
    input  logic                tx_busy,
    input  logic                rx_valid,
    input  bridge_pkg::data_t   rx_data
);

    bridge_pkg::ctrl_state_e state;
    bridge_pkg::frame_t      frame_q;                 // Latched bridged request
    logic                    tx_seen;                 // tx_busy observed high
    logic                    is_bridge;
    logic                    rx_take;

    assign is_bridge = req_addr[bridge_pkg::addr_width-1];
    assign rx_take   = (state == bridge_pkg::st_rx_wait) && rx_valid;

    // ----------------------------------------
    // Local path, straight to the store
    // ----------------------------------------
    assign mem.wen   = req && !is_bridge && (req_op == bridge_pkg::op_write);
    assign mem.ren   = req && !is_bridge && (req_op == bridge_pkg::op_read);
    assign mem.addr  = req_addr[bridge_pkg::addr_width-2:0];
    assign mem.wdata = req_wdata;

    // Transmitter load
    assign tx_start = (state == bridge_pkg::st_send);
    assign tx_frame = frame_q;

    // ----------------------------------------
    // Bridge FSM and busy flag
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= bridge_pkg::st_idle;
            busy    <= 1'b0;
            tx_seen <= 1'b0;
        end else begin
            case (state)
                bridge_pkg::st_idle: if (req && is_bridge) begin
                    state <= bridge_pkg::st_send;
                    busy  <= 1'b1;                    // High from the next cycle
                end
                bridge_pkg::st_send: begin
                    state   <= bridge_pkg::st_tx_wait;
                    tx_seen <= 1'b0;
                end
                bridge_pkg::st_tx_wait: begin
                    if (tx_busy) tx_seen <= 1'b1;
                    if (tx_seen && !tx_busy) begin    // Stop bit has gone out
                        if (frame_q.mode == bridge_pkg::op_write) begin
                            state <= bridge_pkg::st_idle;
                            busy  <= 1'b0;
                        end else begin
                            state <= bridge_pkg::st_rx_wait;
                        end
                    end
                end
                bridge_pkg::st_rx_wait: if (rx_valid) begin
                    state <= bridge_pkg::st_idle;
                    busy  <= 1'b0;                    // Drops with rsp_valid
                end
                default: state <= bridge_pkg::st_idle;
            endcase
        end
    end

    // Frame capture, data field zeroed for reads
    always_ff @(posedge clk) begin
        if (state == bridge_pkg::st_idle && req && is_bridge) begin
            frame_q.mode <= req_op;
            frame_q.data <= (req_op == bridge_pkg::op_write) ? req_wdata : '0;
            frame_q.addr <= req_addr;
        end
    end

    // ----------------------------------------
    // Response register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= mem.rvalid || rx_take;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.rvalid) begin
            rsp_rdata <= mem.rdata;                   // Local read, 2 cycles after req
        end else if (rx_take) begin
            rsp_rdata <= rx_data;                     // Remote byte
        end
    end

    // Requester must hold off while a bridged op runs
    a_no_req_when_busy: assert property (@(posedge clk) disable iff (!rstn)
        busy |-> !req)
        else $error("bridge_ctrl: req while busy");

    // Local reads drain before the frame starts, remote byte comes later
    a_no_rsp_in_tx_wait: assert property (@(posedge clk) disable iff (!rstn)
        (state == bridge_pkg::st_tx_wait) |-> !rsp_valid)
        else $error("bridge_ctrl: rsp_valid during transmission");

endmodule

// ==== verilog/bridge_pkg.sv ====
// Shared widths, request frame struct, operation and controller state enums
package bridge_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int data_width = 8;
    localparam int addr_width = 12;                   // Top bit selects the bridge

    typedef logic [data_width-1:0] data_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [addr_width-2:0] local_addr_t;      // Local store index, top bit dropped

    // Request kind, also the mode bit of a frame
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } op_e;

    // Serial request frame, mode sits in the MSB
    typedef struct packed {
        op_e   mode;
        data_t data;                                  // Zero for reads
        addr_t addr;
    } frame_t;

    localparam int frame_width = $bits(frame_t);      // 21

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_send    = 2'd1,                            // Load the transmitter
        st_tx_wait = 2'd2,                            // Frame on the line
        st_rx_wait = 2'd3                             // Wait for the response byte
    } ctrl_state_e;

endpackage

// ==== verilog/bus_bridge_slave.sv ====
// Top level of the bus bridge slave, instances and wiring only
`timescale 1ns/1ps

module bus_bridge_slave #(
    parameter int clks_per_bit = 5208,                // UART bit period in clocks
    parameter int local_depth  = 2048                 // Local store size in bytes
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              req,
    input  bridge_pkg::op_e   req_op,
    input  bridge_pkg::addr_t req_addr,
    input  bridge_pkg::data_t req_wdata,
    output logic              busy,
    output logic              rsp_valid,
    output bridge_pkg::data_t rsp_rdata,
    output logic              u_tx,                   // To remote node
    input  logic              u_rx                    // From remote node
);

    // ----------------------------------------
    // Internal links
    // ----------------------------------------
    logic               tx_start;
    bridge_pkg::frame_t tx_frame;
    logic               tx_busy;
    logic               rx_valid;
    bridge_pkg::data_t  rx_data;

    local_mem_if mem_if_inst ();

    bridge_ctrl bridge_ctrl_inst (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .mem       (mem_if_inst.ctrl),
        .tx_start  (tx_start),
        .tx_frame  (tx_frame),
        .tx_busy   (tx_busy),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data)
    );

    local_mem #(.local_depth(local_depth)) local_mem_inst (
        .clk  (clk),
        .rstn (rstn),
        .bus  (mem_if_inst.mem)
    );

    // Serial link to the remote node
    uart_tx #(.clks_per_bit(clks_per_bit)) uart_tx_inst (
        .clk      (clk),
        .rstn     (rstn),
        .tx_start (tx_start),
        .tx_frame (tx_frame),
        .tx_busy  (tx_busy),
        .u_tx     (u_tx)
    );

    uart_rx #(.clks_per_bit(clks_per_bit)) uart_rx_inst (
        .clk      (clk),
        .rstn     (rstn),
        .u_rx     (u_rx),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

endmodule

// ==== verilog/local_mem.sv ====
// Local byte store with synchronous write and registered read
`timescale 1ns/1ps

module local_mem #(
    parameter int local_depth = 2048                  // Up to 2048 bytes
) (
    input  logic        clk,
    input  logic        rstn,
    local_mem_if.mem    bus
);

    bridge_pkg::data_t mem_array [local_depth];
    logic              in_range;

    // Indices past the depth are ignored on write and read as zero
    assign in_range = (int'(bus.addr) < local_depth);

    // ----------------------------------------
    // Storage and read data
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (bus.wen && in_range) begin
            mem_array[bus.addr] <= bus.wdata;
        end
        if (bus.ren) begin
            bus.rdata <= in_range ? mem_array[bus.addr] : '0;
        end
    end

    // Read strobe follows ren by one cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bus.rvalid <= 1'b0;
        end else begin
            bus.rvalid <= bus.ren;
        end
    end

    // Controller decodes one op per request
    a_no_wen_with_ren: assert property (@(posedge clk) disable iff (!rstn)
        !(bus.wen && bus.ren))
        else $error("local_mem: wen and ren high together");

endmodule

// ==== verilog/local_mem_if.sv ====
// Interface between the controller and the local store, with ctrl and mem modports
`timescale 1ns/1ps

interface local_mem_if;

    logic                    wen;     // Write strobe
    logic                    ren;     // Read strobe
    bridge_pkg::local_addr_t addr;
    bridge_pkg::data_t       wdata;
    bridge_pkg::data_t       rdata;   // Registered read data
    logic                    rvalid;  // One cycle after ren

    // Controller side
    modport ctrl (output wen, ren, addr, wdata, input rdata, rvalid);

    // Memory side
    modport mem (input wen, ren, addr, wdata, output rdata, rvalid);

endinterface

// ==== verilog/uart_rx.sv ====
// UART deserialiser for one response byte with mid-bit sampling and stop check
`timescale 1ns/1ps

module uart_rx #(
    parameter int clks_per_bit = 5208
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              u_rx,
    output logic              rx_valid,               // One-cycle strobe
    output bridge_pkg::data_t rx_data
);

    localparam int timer_width = $clog2(clks_per_bit + 1);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,                                     // Confirm start bit at mid-period
        rx_bits,
        rx_stop
    } rx_state_e;

    rx_state_e              state;
    logic [2:0]             sync_q;                   // Two sync flops plus edge history
    logic [timer_width-1:0] timer_q;
    logic [2:0]             bit_cnt_q;                // Data bit index
    bridge_pkg::data_t      shift_q;
    logic                   line;
    logic                   start_edge;
    logic                   half_end;
    logic                   bit_end;

    assign line       = sync_q[1];
    assign start_edge = sync_q[2] && !sync_q[1];      // High to low
    assign half_end   = (timer_q == timer_width'(clks_per_bit / 2 - 1));
    assign bit_end    = (timer_q == timer_width'(clks_per_bit - 1));

    // ----------------------------------------
    // Synchroniser
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync_q <= '1;                             // Idle line level
        end else begin
            sync_q <= {sync_q[1:0], u_rx};
        end
    end

    // ----------------------------------------
    // Receive FSM
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= rx_idle;
            timer_q   <= '0;
            bit_cnt_q <= '0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            timer_q  <= timer_q + 1'b1;
            case (state)
                rx_idle: begin
                    timer_q <= '0;
                    if (start_edge) state <= rx_start;
                end
                rx_start: if (half_end) begin
                    timer_q   <= '0;                  // Now aligned to mid-bit
                    bit_cnt_q <= '0;
                    state     <= line ? rx_idle : rx_bits;  // Glitch if high again
                end
                rx_bits: if (bit_end) begin
                    timer_q   <= '0;
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q == 3'd7) state <= rx_stop;
                end
                rx_stop: if (bit_end) begin
                    timer_q  <= '0;
                    rx_valid <= line;                 // Bad stop bit drops the byte
                    state    <= rx_idle;
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // Data bits enter at the top so the LSB ends in bit 0
    always_ff @(posedge clk) begin
        if (state == rx_bits && bit_end) begin
            shift_q <= {line, shift_q[7:1]};
        end
        if (state == rx_stop && bit_end) begin
            rx_data <= shift_q;
        end
    end

endmodule

// ==== verilog/uart_tx.sv ====
// UART serialiser for one request frame with start bit, LSB first, stop bit
`timescale 1ns/1ps

module uart_tx #(
    parameter int clks_per_bit = 5208
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               tx_start,              // One-cycle load strobe
    input  bridge_pkg::frame_t tx_frame,
    output logic               tx_busy,
    output logic               u_tx
);

    localparam int n_bits      = bridge_pkg::frame_width + 2;   // Start, frame, stop
    localparam int timer_width = $clog2(clks_per_bit + 1);
    localparam int cnt_width   = $clog2(n_bits);

    logic [n_bits-1:0]      shift_q;                  // Bit 0 is on the line
    logic [timer_width-1:0] timer_q;                  // Cycles within one bit
    logic [cnt_width-1:0]   bit_cnt_q;                // Bits sent so far
    logic                   bit_end;

    assign bit_end = (timer_q == timer_width'(clks_per_bit - 1));
    assign u_tx    = shift_q[0];                      // Straight from a flop, no glitches

    // ----------------------------------------
    // Shift register and bit timing
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            shift_q   <= '1;                          // Line idles high
            timer_q   <= '0;
            bit_cnt_q <= '0;
            tx_busy   <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                shift_q   <= {1'b1, tx_frame, 1'b0};  // Stop, frame, start
                timer_q   <= '0;
                bit_cnt_q <= '0;
                tx_busy   <= 1'b1;
            end
        end else if (bit_end) begin
            timer_q <= '0;
            shift_q <= {1'b1, shift_q[n_bits-1:1]};   // Refill with idle level
            if (bit_cnt_q == cnt_width'(n_bits - 1)) begin
                bit_cnt_q <= '0;                      // Stop bit done
                tx_busy   <= 1'b0;
            end else begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end else begin
            timer_q <= timer_q + 1'b1;
        end
    end

    // A new frame would cut the one on the line
    a_no_start_when_busy: assert property (@(posedge clk) disable iff (!rstn)
        tx_start |-> !tx_busy)
        else $error("uart_tx: tx_start while busy");

endmodule
